// File: cpu_backend.sv
`timescale 1ns/1ps

module cpu_backend (
    input  logic          clk,
    input  logic          resetn,
    input  logic          i_uop_valid,
    output logic          o_uop_ready,
    input  cpu_pkg::uop_t i_uop,
    output logic          o_wb_valid,
    output cpu_pkg::wb_t  o_wb
);

    // DE register
    logic              de_valid_q;
    cpu_pkg::uop_t     de_uop_q;
    cpu_pkg::reg_idx_t de_ra_sel_q;
    cpu_pkg::reg_idx_t de_rb_sel_q;

    // EX1 output register
    logic                ex1_valid_q;
    cpu_pkg::ex_result_t ex1_q;

    cpu_pkg::xlen_t      rf_a;
    cpu_pkg::xlen_t      rf_b;
    cpu_pkg::xlen_t      ex_rs1;
    cpu_pkg::xlen_t      ex_rs2;
    cpu_pkg::ex_result_t ex_result;
    logic                stall;

    logic              ex2_ready;
    logic              ex2_busy;
    cpu_pkg::reg_idx_t ex2_rd;

    logic ex1_free;
    logic accept;
    logic de_advance;

    assign ex1_free = !ex1_valid_q || ex2_ready;
    // Stale DE contents never hold up issue
    assign o_uop_ready = !(de_valid_q && stall) && ex1_free;
    assign accept = i_uop_valid && o_uop_ready;
    assign de_advance = de_valid_q && o_uop_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            de_valid_q <= 1'b0;
            ex1_valid_q <= 1'b0;
        end else begin
            if (accept) begin
                de_valid_q <= 1'b1;
            end else if (de_advance) begin
                de_valid_q <= 1'b0;
            end

            if (de_advance) begin
                ex1_valid_q <= 1'b1;
            end else if (ex1_valid_q && ex2_ready) begin
                ex1_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            de_uop_q <= i_uop;
            de_ra_sel_q <= i_uop.rs1;
            de_rb_sel_q <= i_uop.rs2;
        end
        if (de_advance) begin
            ex1_q <= ex_result;
        end
    end

    reg_file u_rf (
        .clk       (clk),
        .resetn    (resetn),
        .i_ra_sel  (de_ra_sel_q),
        .i_rb_sel  (de_rb_sel_q),
        .o_ra_data (rf_a),
        .o_rb_data (rf_b),
        .i_w_en    (o_wb_valid),
        .i_w_sel   (o_wb.rd),
        .i_w_data  (o_wb.data)
    );

    operand_bypass u_bypass (
        .i_uop       (de_uop_q),
        .i_rf_a      (rf_a),
        .i_rf_b      (rf_b),
        .i_ex1_valid (ex1_valid_q),
        .i_ex1       (ex1_q),
        .i_ex2_busy  (ex2_busy),
        .i_ex2_rd    (ex2_rd),
        .i_wb_valid  (o_wb_valid),
        .i_wb_data   (o_wb.data),
        .o_rs1       (ex_rs1),
        .o_rs2       (ex_rs2),
        .o_stall     (stall)
    );

    stage_ex u_ex (
        .i_uop    (de_uop_q),
        .i_rs1    (ex_rs1),
        .i_rs2    (ex_rs2),
        .o_result (ex_result)
    );

    stage_ex2 u_ex2 (
        .clk        (clk),
        .resetn     (resetn),
        .i_valid    (ex1_valid_q),
        .o_ready    (ex2_ready),
        .i_ex       (ex1_q),
        .o_busy     (ex2_busy),
        .o_rd       (ex2_rd),
        .o_wb_valid (o_wb_valid),
        .o_wb       (o_wb)
    );

endmodule

// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data path width
`define CPU_XLEN 32

// Register table size and index width
`define CPU_NREGS 32
`define CPU_REG_IDX_W 5

// Register stages in the multiplier
`define CPU_MUL_LATENCY 2

`endif

// File: cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] xlen_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    // Functional unit select
    typedef enum logic [1:0] {
        OP_ALU = 2'd0,
        OP_MUL = 2'd1,
        OP_DIV = 2'd2
    } op_type_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL_MUL   = 2'd0,
        MUL_MULH  = 2'd1,
        MUL_MULHU = 2'd2
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV_DIV  = 2'd0,
        DIV_DIVU = 2'd1,
        DIV_REM  = 2'd2,
        DIV_REMU = 2'd3
    } div_op_e;

    typedef struct packed {
        op_type_e op_type;
        alu_op_e  alu_op;
        mul_op_e  mul_op;
        div_op_e  div_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;
        // Already sign-extended
        xlen_t    imm;
    } uop_t;

    typedef struct packed {
        uop_t  uop;
        // ALU result, or operand a for MUL and DIV
        xlen_t data;
        xlen_t data2;
        logic  value_valid;
    } ex_result_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } div_state_e;

endpackage

// File: div_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module div_unit (
    input  logic             clk,
    input  logic             resetn,
    input  logic             i_start,
    input  cpu_pkg::div_op_e i_op,
    input  cpu_pkg::xlen_t   i_a,
    input  cpu_pkg::xlen_t   i_b,
    output logic             o_valid,
    output cpu_pkg::xlen_t   o_value
);

    localparam int XLEN  = `CPU_XLEN;
    localparam int CNT_W = $clog2(XLEN + 1);

    cpu_pkg::div_state_e state_q;
    logic [CNT_W-1:0]    cnt_q;

    cpu_pkg::xlen_t rem_q;
    cpu_pkg::xlen_t quo_q;
    cpu_pkg::xlen_t dvs_q;
    logic           neg_quo_q;
    logic           neg_rem_q;
    logic           use_rem_q;

    logic           is_signed;
    logic           a_neg;
    logic           b_neg;
    cpu_pkg::xlen_t a_mag;
    cpu_pkg::xlen_t b_mag;
    logic [XLEN:0]  trial;
    cpu_pkg::xlen_t quo_fix;
    cpu_pkg::xlen_t rem_fix;

    always_comb begin
        is_signed = i_op == cpu_pkg::DIV_DIV || i_op == cpu_pkg::DIV_REM;
        a_neg = is_signed && i_a[XLEN-1];
        b_neg = is_signed && i_b[XLEN-1];
        a_mag = a_neg ? -i_a : i_a;
        b_mag = b_neg ? -i_b : i_b;
    end

    // Shift in next dividend bit and try the subtract
    assign trial = {rem_q, quo_q[XLEN-1]} - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= cpu_pkg::IDLE;
            cnt_q <= '0;
        end else begin
            case (state_q)
                cpu_pkg::IDLE: begin
                    if (i_start) begin
                        state_q <= cpu_pkg::RUN;
                        cnt_q <= CNT_W'(XLEN);
                    end
                end
                cpu_pkg::RUN: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == CNT_W'(1)) begin
                        state_q <= cpu_pkg::DONE;
                    end
                end
                cpu_pkg::DONE: state_q <= cpu_pkg::IDLE;
                default: state_q <= cpu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == cpu_pkg::IDLE && i_start) begin
            rem_q <= '0;
            quo_q <= a_mag;
            dvs_q <= b_mag;
            // Zero divisor leaves all ones and the dividend unsigned
            neg_quo_q <= (a_neg ^ b_neg) && (i_b != '0);
            neg_rem_q <= a_neg;
            use_rem_q <= i_op == cpu_pkg::DIV_REM || i_op == cpu_pkg::DIV_REMU;
        end else if (state_q == cpu_pkg::RUN) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // Most negative over -1 wraps back to itself with rem 0
    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    assign o_valid = state_q == cpu_pkg::DONE;
    assign o_value = use_rem_q ? rem_fix : quo_fix;

    a_start_idle: assert property (
        @(posedge clk) disable iff (!resetn)
        i_start |-> state_q == cpu_pkg::IDLE
    );

endmodule

// File: flist.f
+incdir+.
cpu_pkg.sv
reg_file.sv
operand_bypass.sv
stage_ex.sv
mul_unit.sv
div_unit.sv
stage_ex2.sv
cpu_backend.sv
tb_cpu_backend.sv

// File: mul_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module mul_unit (
    input  logic             clk,
    input  logic             resetn,
    input  logic             i_start,
    input  cpu_pkg::mul_op_e i_op,
    input  cpu_pkg::xlen_t   i_a,
    input  cpu_pkg::xlen_t   i_b,
    output logic             o_valid,
    output cpu_pkg::xlen_t   o_value
);

    localparam int XLEN = `CPU_XLEN;
    localparam int LAT  = `CPU_MUL_LATENCY;

    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] full;

    logic [LAT-1:0]    vld_q;
    logic [LAT-1:0]    hi_q;
    logic [2*XLEN-1:0] prod_q [LAT];

    // Sign extension only for MULH
    always_comb begin
        a_ext = {i_op == cpu_pkg::MUL_MULH && i_a[XLEN-1], i_a};
        b_ext = {i_op == cpu_pkg::MUL_MULH && i_b[XLEN-1], i_b};
        full = a_ext * b_ext;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            vld_q <= '0;
        end else begin
            vld_q <= LAT'({vld_q, i_start});
        end
    end

    always_ff @(posedge clk) begin
        hi_q <= LAT'({hi_q, i_op != cpu_pkg::MUL_MUL});
        if (i_start) begin
            prod_q[0] <= full[2*XLEN-1:0];
        end
        for (int i = 1; i < LAT; i++) begin
            if (vld_q[i-1]) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    assign o_valid = vld_q[LAT-1];
    assign o_value = hi_q[LAT-1] ? prod_q[LAT-1][2*XLEN-1:XLEN] : prod_q[LAT-1][XLEN-1:0];

endmodule

// File: operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  cpu_pkg::uop_t       i_uop,
    input  cpu_pkg::xlen_t      i_rf_a,
    input  cpu_pkg::xlen_t      i_rf_b,
    input  logic                i_ex1_valid,
    input  cpu_pkg::ex_result_t i_ex1,
    input  logic                i_ex2_busy,
    input  cpu_pkg::reg_idx_t   i_ex2_rd,
    input  logic                i_wb_valid,
    input  cpu_pkg::xlen_t      i_wb_data,
    output cpu_pkg::xlen_t      o_rs1,
    output cpu_pkg::xlen_t      o_rs2,
    output logic                o_stall
);

    cpu_pkg::reg_idx_t src [2];
    cpu_pkg::xlen_t    rf_val [2];
    cpu_pkg::xlen_t    fwd [2];
    logic              used [2];
    logic              wait_src [2];

    always_comb begin
        src[0] = i_uop.rs1;
        src[1] = i_uop.rs2;
        rf_val[0] = i_rf_a;
        rf_val[1] = i_rf_b;
        used[0] = 1'b1;
        // Immediate replaces rs2
        used[1] = !i_uop.use_imm;

        for (int i = 0; i < 2; i++) begin
            fwd[i] = rf_val[i];
            wait_src[i] = 1'b0;
            if (used[i] && src[i] != '0) begin
                // Older producer sitting in EX2
                if (i_ex2_busy && i_ex2_rd == src[i]) begin
                    fwd[i] = i_wb_data;
                    wait_src[i] = !i_wb_valid;
                end
                // Younger producer in EX1 wins
                if (i_ex1_valid && i_ex1.uop.rd == src[i]) begin
                    fwd[i] = i_ex1.data;
                    wait_src[i] = !i_ex1.value_valid;
                end
            end
        end
    end

    assign o_rs1 = fwd[0];
    assign o_rs2 = fwd[1];
    assign o_stall = wait_src[0] || wait_src[1];

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file (
    input  logic              clk,
    input  logic              resetn,
    input  cpu_pkg::reg_idx_t i_ra_sel,
    input  cpu_pkg::reg_idx_t i_rb_sel,
    output cpu_pkg::xlen_t    o_ra_data,
    output cpu_pkg::xlen_t    o_rb_data,
    input  logic              i_w_en,
    input  cpu_pkg::reg_idx_t i_w_sel,
    input  cpu_pkg::xlen_t    i_w_data
);

    localparam int NREGS = `CPU_NREGS;

    // x0 has no storage
    cpu_pkg::xlen_t regs_q [1:NREGS-1];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 1; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_w_en && i_w_sel != '0) begin
            regs_q[i_w_sel] <= i_w_data;
        end
    end

    assign o_ra_data = (i_ra_sel == '0) ? '0 : regs_q[i_ra_sel];
    assign o_rb_data = (i_rb_sel == '0) ? '0 : regs_q[i_rb_sel];

    // Writeback from EX2 must carry a resolved destination
    a_w_sel_known: assert property (
        @(posedge clk) disable iff (!resetn)
        i_w_en |-> !$isunknown(i_w_sel)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cpu_backend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu_backend \
    -f flist.f \
    --Mdir obj_dir \
    -o sim_cpu_backend
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_cpu_backend
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// File: stage_ex.sv
`timescale 1ns/1ps

module stage_ex (
    input  cpu_pkg::uop_t       i_uop,
    input  cpu_pkg::xlen_t      i_rs1,
    input  cpu_pkg::xlen_t      i_rs2,
    output cpu_pkg::ex_result_t o_result
);

    localparam int SHAMT_W = $clog2($bits(cpu_pkg::xlen_t));

    cpu_pkg::xlen_t     opb;
    cpu_pkg::xlen_t     alu;
    logic [SHAMT_W-1:0] shamt;
    logic               is_alu;

    assign opb = i_uop.use_imm ? i_uop.imm : i_rs2;
    assign shamt = opb[SHAMT_W-1:0];
    assign is_alu = i_uop.op_type == cpu_pkg::OP_ALU;

    always_comb begin
        case (i_uop.alu_op)
            cpu_pkg::ALU_ADD:  alu = i_rs1 + opb;
            cpu_pkg::ALU_SUB:  alu = i_rs1 - opb;
            cpu_pkg::ALU_AND:  alu = i_rs1 & opb;
            cpu_pkg::ALU_OR:   alu = i_rs1 | opb;
            cpu_pkg::ALU_XOR:  alu = i_rs1 ^ opb;
            cpu_pkg::ALU_SLT:  alu = cpu_pkg::xlen_t'($signed(i_rs1) < $signed(opb));
            cpu_pkg::ALU_SLTU: alu = cpu_pkg::xlen_t'(i_rs1 < opb);
            cpu_pkg::ALU_SLL:  alu = i_rs1 << shamt;
            cpu_pkg::ALU_SRL:  alu = i_rs1 >> shamt;
            cpu_pkg::ALU_SRA:  alu = $signed(i_rs1) >>> shamt;
            default:           alu = '0;
        endcase
    end

    // MUL and DIV carry both operands on to EX2
    always_comb begin
        o_result.uop = i_uop;
        o_result.value_valid = is_alu;
        o_result.data = is_alu ? alu : i_rs1;
        o_result.data2 = opb;
    end

endmodule

// File: stage_ex2.sv
`timescale 1ns/1ps

module stage_ex2 (
    input  logic                clk,
    input  logic                resetn,
    input  logic                i_valid,
    output logic                o_ready,
    input  cpu_pkg::ex_result_t i_ex,
    output logic                o_busy,
    output cpu_pkg::reg_idx_t   o_rd,
    output logic                o_wb_valid,
    output cpu_pkg::wb_t        o_wb
);

    logic                busy_q;
    logic                start_q;
    logic                enter;
    cpu_pkg::ex_result_t ex_q;

    logic           mul_valid;
    cpu_pkg::xlen_t mul_value;
    logic           div_valid;
    cpu_pkg::xlen_t div_value;
    logic           fire;
    cpu_pkg::xlen_t wb_data;

    // Ready comes back in the writeback cycle
    assign o_ready = !busy_q || o_wb_valid;
    assign enter = i_valid && o_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= enter && i_ex.uop.op_type != cpu_pkg::OP_ALU;
            if (enter) begin
                busy_q <= 1'b1;
            end else if (o_wb_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enter) begin
            ex_q <= i_ex;
        end
    end

    // Units start one cycle after entry from the latched operands
    mul_unit u_mul (
        .clk     (clk),
        .resetn  (resetn),
        .i_start (start_q && ex_q.uop.op_type == cpu_pkg::OP_MUL),
        .i_op    (ex_q.uop.mul_op),
        .i_a     (ex_q.data),
        .i_b     (ex_q.data2),
        .o_valid (mul_valid),
        .o_value (mul_value)
    );

    div_unit u_div (
        .clk     (clk),
        .resetn  (resetn),
        .i_start (start_q && ex_q.uop.op_type == cpu_pkg::OP_DIV),
        .i_op    (ex_q.uop.div_op),
        .i_a     (ex_q.data),
        .i_b     (ex_q.data2),
        .o_valid (div_valid),
        .o_value (div_value)
    );

    always_comb begin
        case (ex_q.uop.op_type)
            cpu_pkg::OP_MUL: begin
                fire = mul_valid;
                wb_data = mul_value;
            end
            cpu_pkg::OP_DIV: begin
                fire = div_valid;
                wb_data = div_value;
            end
            default: begin
                fire = 1'b1;
                wb_data = ex_q.data;
            end
        endcase
    end

    assign o_wb_valid = busy_q && fire;
    assign o_wb.rd = ex_q.uop.rd;
    assign o_wb.data = wb_data;
    assign o_busy = busy_q;
    assign o_rd = ex_q.uop.rd;

    // A unit only completes for the op that owns EX2
    a_unit_done_busy: assert property (
        @(posedge clk) disable iff (!resetn)
        (mul_valid || div_valid) |-> busy_q
    );

endmodule

// File: tb_cpu_backend.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu_backend;

    localparam int RESET_CYCLES = 5;
    localparam int MAX_ENTRIES = 128;
    localparam logic [31:0] SEED = 32'hb18c7d25;

    typedef struct packed {
        cpu_pkg::uop_t uop;
        cpu_pkg::wb_t  wb;
        // Issue right after the previous op with no idle gap
        logic          b2b;
        // Wait for every earlier writeback before issue
        logic          drain;
        // Issue must be blocked in the cycle after this op is taken
        logic          chk_stall;
    } entry_t;

    logic          clk;
    logic          resetn;
    logic          i_uop_valid;
    logic          o_uop_ready;
    cpu_pkg::uop_t i_uop;
    logic          o_wb_valid;
    cpu_pkg::wb_t  o_wb;

    entry_t       tbl [MAX_ENTRIES];
    int           n_entries;
    logic         b2b_mode;
    logic         table_loaded;
    cpu_pkg::wb_t exp_q [$];
    cpu_pkg::wb_t wb_expected;

    cpu_backend UUT (
        .clk         (clk),
        .resetn      (resetn),
        .i_uop_valid (i_uop_valid),
        .o_uop_ready (o_uop_ready),
        .i_uop       (i_uop),
        .o_wb_valid  (o_wb_valid),
        .o_wb        (o_wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_wb(input cpu_pkg::wb_t actual, input cpu_pkg::wb_t expected);
        if (actual !== expected) begin
            report_failure($sformatf(
                "[ERROR] %0t: writeback expected rd %0d data %h, got rd %0d data %h",
                $time, expected.rd, expected.data, actual.rd, actual.data));
        end
    endtask

    task automatic check_ready(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %0t: %s, expected %b, got %b",
                $time, what, expected, actual));
        end
    endtask

    function automatic cpu_pkg::uop_t make_uop(
        input cpu_pkg::op_type_e op_type,
        input cpu_pkg::alu_op_e  alu_op,
        input cpu_pkg::mul_op_e  mul_op,
        input cpu_pkg::div_op_e  div_op,
        input cpu_pkg::reg_idx_t rd,
        input cpu_pkg::reg_idx_t rs1,
        input cpu_pkg::reg_idx_t rs2,
        input logic              use_imm,
        input cpu_pkg::xlen_t    imm
    );
        cpu_pkg::uop_t u;
        u.op_type = op_type;
        u.alu_op = alu_op;
        u.mul_op = mul_op;
        u.div_op = div_op;
        u.rd = rd;
        u.rs1 = rs1;
        u.rs2 = rs2;
        u.use_imm = use_imm;
        u.imm = imm;
        return u;
    endfunction

    function automatic cpu_pkg::uop_t alu_rr(input cpu_pkg::alu_op_e op,
        input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rs1, input cpu_pkg::reg_idx_t rs2);
        return make_uop(cpu_pkg::OP_ALU, op, cpu_pkg::MUL_MUL, cpu_pkg::DIV_DIV,
            rd, rs1, rs2, 1'b0, '0);
    endfunction

    function automatic cpu_pkg::uop_t alu_ri(input cpu_pkg::alu_op_e op,
        input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rs1, input cpu_pkg::xlen_t imm);
        return make_uop(cpu_pkg::OP_ALU, op, cpu_pkg::MUL_MUL, cpu_pkg::DIV_DIV,
            rd, rs1, 5'd0, 1'b1, imm);
    endfunction

    function automatic cpu_pkg::uop_t mul_op(input cpu_pkg::mul_op_e op,
        input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rs1, input cpu_pkg::reg_idx_t rs2,
        input logic use_imm, input cpu_pkg::xlen_t imm);
        return make_uop(cpu_pkg::OP_MUL, cpu_pkg::ALU_ADD, op, cpu_pkg::DIV_DIV,
            rd, rs1, rs2, use_imm, imm);
    endfunction

    function automatic cpu_pkg::uop_t div_op(input cpu_pkg::div_op_e op,
        input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rs1, input cpu_pkg::reg_idx_t rs2,
        input logic use_imm, input cpu_pkg::xlen_t imm);
        return make_uop(cpu_pkg::OP_DIV, cpu_pkg::ALU_ADD, cpu_pkg::MUL_MUL, op,
            rd, rs1, rs2, use_imm, imm);
    endfunction

    task automatic push_entry(input cpu_pkg::uop_t u, input cpu_pkg::xlen_t data);
        tbl[n_entries].uop = u;
        tbl[n_entries].wb.rd = u.rd;
        tbl[n_entries].wb.data = data;
        tbl[n_entries].b2b = b2b_mode;
        tbl[n_entries].drain = 1'b0;
        tbl[n_entries].chk_stall = 1'b0;
        n_entries++;
    endtask

    task automatic load_table();
        n_entries = 0;
        b2b_mode = 1'b0;
        // Every register reads zero out of reset
        for (int k = 0; k < 16; k++) begin
            push_entry(alu_rr(cpu_pkg::ALU_OR, 5'd0, cpu_pkg::reg_idx_t'(2 * k + 1),
                cpu_pkg::reg_idx_t'((2 * k + 2) % 32)), 32'h0);
        end

        // ALU ops in register form then immediate form
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd1, 5'd0, 32'hF000_00F5), 32'hF000_00F5);
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd2, 5'd0, 32'h0000_0024), 32'h0000_0024);
        push_entry(alu_rr(cpu_pkg::ALU_ADD,  5'd3,  5'd1, 5'd2), 32'hF000_0119);
        push_entry(alu_rr(cpu_pkg::ALU_SUB,  5'd4,  5'd1, 5'd2), 32'hF000_00D1);
        push_entry(alu_rr(cpu_pkg::ALU_AND,  5'd5,  5'd1, 5'd2), 32'h0000_0024);
        push_entry(alu_rr(cpu_pkg::ALU_OR,   5'd6,  5'd1, 5'd2), 32'hF000_00F5);
        push_entry(alu_rr(cpu_pkg::ALU_XOR,  5'd7,  5'd1, 5'd2), 32'hF000_00D1);
        push_entry(alu_rr(cpu_pkg::ALU_SLT,  5'd8,  5'd1, 5'd2), 32'h0000_0001);
        push_entry(alu_rr(cpu_pkg::ALU_SLTU, 5'd9,  5'd1, 5'd2), 32'h0000_0000);
        push_entry(alu_rr(cpu_pkg::ALU_SLL,  5'd10, 5'd1, 5'd2), 32'h0000_0F50);
        push_entry(alu_rr(cpu_pkg::ALU_SRL,  5'd11, 5'd1, 5'd2), 32'h0F00_000F);
        push_entry(alu_rr(cpu_pkg::ALU_SRA,  5'd12, 5'd1, 5'd2), 32'hFF00_000F);
        push_entry(alu_ri(cpu_pkg::ALU_ADD,  5'd13, 5'd1, 32'hFFFF_FFF8), 32'hF000_00ED);
        push_entry(alu_ri(cpu_pkg::ALU_SUB,  5'd14, 5'd1, 32'hFFFF_FFF8), 32'hF000_00FD);
        push_entry(alu_ri(cpu_pkg::ALU_AND,  5'd15, 5'd1, 32'hFFFF_FFF8), 32'hF000_00F0);
        push_entry(alu_ri(cpu_pkg::ALU_OR,   5'd16, 5'd1, 32'hFFFF_FFF8), 32'hFFFF_FFFD);
        push_entry(alu_ri(cpu_pkg::ALU_XOR,  5'd17, 5'd1, 32'hFFFF_FFF8), 32'h0FFF_FF0D);
        push_entry(alu_ri(cpu_pkg::ALU_SLT,  5'd18, 5'd1, 32'hFFFF_FFF8), 32'h0000_0001);
        push_entry(alu_ri(cpu_pkg::ALU_SLTU, 5'd19, 5'd1, 32'hFFFF_FFF8), 32'h0000_0001);
        push_entry(alu_ri(cpu_pkg::ALU_SLL,  5'd20, 5'd1, 32'hFFFF_FFF8), 32'hF500_0000);
        push_entry(alu_ri(cpu_pkg::ALU_SRL,  5'd21, 5'd1, 32'hFFFF_FFF8), 32'h0000_00F0);
        push_entry(alu_ri(cpu_pkg::ALU_SRA,  5'd22, 5'd1, 32'hFFFF_FFF8), 32'hFFFF_FFF0);
        // x0 write shows on the bus but x0 still reads zero
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd0, 5'd2, 32'h0000_0005), 32'h0000_0029);
        push_entry(alu_rr(cpu_pkg::ALU_ADD, 5'd24, 5'd0, 5'd0), 32'h0000_0000);
        push_entry(alu_rr(cpu_pkg::ALU_OR,  5'd25, 5'd0, 5'd2), 32'h0000_0024);

        // Dependent chain through both bypass paths
        b2b_mode = 1'b1;
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd23, 5'd0, 32'h1), 32'h0000_0001);
        push_entry(alu_rr(cpu_pkg::ALU_ADD, 5'd23, 5'd23, 5'd23), 32'h0000_0002);
        push_entry(alu_rr(cpu_pkg::ALU_ADD, 5'd23, 5'd23, 5'd23), 32'h0000_0004);
        push_entry(alu_ri(cpu_pkg::ALU_SLL, 5'd24, 5'd23, 32'h3), 32'h0000_0020);
        push_entry(alu_rr(cpu_pkg::ALU_SUB, 5'd25, 5'd24, 5'd23), 32'h0000_001C);
        push_entry(alu_rr(cpu_pkg::ALU_XOR, 5'd26, 5'd25, 5'd24), 32'h0000_003C);
        b2b_mode = 1'b0;

        // Multiplier
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd27, 5'd0, 32'hFFFF_FFFD), 32'hFFFF_FFFD);
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd28, 5'd0, 32'h0000_0007), 32'h0000_0007);
        push_entry(mul_op(cpu_pkg::MUL_MUL,   5'd30, 5'd27, 5'd28, 1'b0, '0), 32'hFFFF_FFEB);
        push_entry(mul_op(cpu_pkg::MUL_MULH,  5'd30, 5'd27, 5'd28, 1'b0, '0), 32'hFFFF_FFFF);
        push_entry(mul_op(cpu_pkg::MUL_MULHU, 5'd30, 5'd27, 5'd28, 1'b0, '0), 32'h0000_0006);
        push_entry(mul_op(cpu_pkg::MUL_MULH,  5'd30, 5'd27, 5'd27, 1'b0, '0), 32'h0000_0000);
        push_entry(mul_op(cpu_pkg::MUL_MULHU, 5'd31, 5'd27, 5'd27, 1'b0, '0), 32'hFFFF_FFFA);
        push_entry(mul_op(cpu_pkg::MUL_MUL, 5'd29, 5'd28, 5'd0, 1'b1, 32'h1_0000), 32'h0007_0000);
        push_entry(mul_op(cpu_pkg::MUL_MUL, 5'd30, 5'd28, 5'd28, 1'b0, '0), 32'h0000_0031);
        tbl[n_entries - 1].drain = 1'b1;
        push_entry(alu_rr(cpu_pkg::ALU_ADD, 5'd31, 5'd30, 5'd28), 32'h0000_0038);
        tbl[n_entries - 1].b2b = 1'b1;
        tbl[n_entries - 1].chk_stall = 1'b1;

        // Divider with zero divisor and signed overflow
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd3, 5'd0, 32'hFFFF_FFEC), 32'hFFFF_FFEC);
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd4, 5'd0, 32'h0000_0006), 32'h0000_0006);
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd5, 5'd0, 32'h0000_0000), 32'h0000_0000);
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd6, 5'd0, 32'h8000_0000), 32'h8000_0000);
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd7, 5'd0, 32'hFFFF_FFFF), 32'hFFFF_FFFF);
        push_entry(div_op(cpu_pkg::DIV_DIV,  5'd8, 5'd3, 5'd4, 1'b0, '0), 32'hFFFF_FFFD);
        push_entry(div_op(cpu_pkg::DIV_REM,  5'd8, 5'd3, 5'd4, 1'b0, '0), 32'hFFFF_FFFE);
        push_entry(div_op(cpu_pkg::DIV_DIVU, 5'd8, 5'd3, 5'd4, 1'b0, '0), 32'h2AAA_AAA7);
        push_entry(div_op(cpu_pkg::DIV_REMU, 5'd8, 5'd3, 5'd4, 1'b0, '0), 32'h0000_0002);
        push_entry(div_op(cpu_pkg::DIV_DIV,  5'd8, 5'd3, 5'd5, 1'b0, '0), 32'hFFFF_FFFF);
        push_entry(div_op(cpu_pkg::DIV_REM,  5'd8, 5'd3, 5'd5, 1'b0, '0), 32'hFFFF_FFEC);
        push_entry(div_op(cpu_pkg::DIV_DIVU, 5'd8, 5'd3, 5'd5, 1'b0, '0), 32'hFFFF_FFFF);
        push_entry(div_op(cpu_pkg::DIV_REMU, 5'd8, 5'd3, 5'd5, 1'b0, '0), 32'hFFFF_FFEC);
        push_entry(div_op(cpu_pkg::DIV_DIV,  5'd8, 5'd6, 5'd7, 1'b0, '0), 32'h8000_0000);
        push_entry(div_op(cpu_pkg::DIV_REM,  5'd9, 5'd6, 5'd7, 1'b0, '0), 32'h0000_0000);
        push_entry(div_op(cpu_pkg::DIV_DIVU, 5'd10, 5'd6, 5'd0, 1'b1, 32'h10), 32'h0800_0000);
        push_entry(alu_rr(cpu_pkg::ALU_ADD, 5'd10, 5'd8, 5'd10), 32'h8800_0000);

        // Mixed sequence
        push_entry(alu_ri(cpu_pkg::ALU_ADD, 5'd11, 5'd0, 32'd100), 32'h0000_0064);
        push_entry(mul_op(cpu_pkg::MUL_MUL, 5'd12, 5'd11, 5'd11, 1'b0, '0), 32'h0000_2710);
        push_entry(div_op(cpu_pkg::DIV_DIVU, 5'd13, 5'd12, 5'd0, 1'b1, 32'd7), 32'h0000_0594);
        push_entry(alu_rr(cpu_pkg::ALU_ADD, 5'd14, 5'd13, 5'd11), 32'h0000_05F8);
        push_entry(div_op(cpu_pkg::DIV_REM, 5'd15, 5'd12, 5'd0, 1'b1, 32'd3), 32'h0000_0001);
        push_entry(mul_op(cpu_pkg::MUL_MULHU, 5'd16, 5'd12, 5'd0, 1'b1, 32'h0010_0000),
            32'h0000_0002);
        push_entry(alu_rr(cpu_pkg::ALU_SUB, 5'd17, 5'd14, 5'd15), 32'h0000_05F7);
        push_entry(mul_op(cpu_pkg::MUL_MUL, 5'd0, 5'd11, 5'd11, 1'b0, '0), 32'h0000_2710);
        push_entry(alu_rr(cpu_pkg::ALU_OR, 5'd18, 5'd0, 5'd17), 32'h0000_05F7);
    endtask

    // Holds the op on the bus until the handshake completes
    task automatic issue_uop(input entry_t e);
        i_uop_valid = 1'b1;
        i_uop = e.uop;
        while (!o_uop_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        exp_q.push_back(e.wb);
        @(negedge clk);
    endtask

    task automatic run_table();
        int     gap;
        entry_t e;
        for (int i = 0; i < n_entries; i++) begin
            e = tbl[i];
            if (e.drain) begin
                i_uop_valid = 1'b0;
                while (exp_q.size() != 0) begin
                    @(negedge clk);
                end
            end else if (!e.b2b) begin
                gap = $urandom % 4;
                if (gap > 0) begin
                    i_uop_valid = 1'b0;
                    repeat (gap) @(negedge clk);
                end
            end
            issue_uop(e);
            if (e.chk_stall) begin
                check_ready(o_uop_ready, 1'b0, "ready while waiting on a MUL result");
            end
        end
        i_uop_valid = 1'b0;
    endtask

    // Writebacks in order against the accepted ops
    always @(negedge clk) begin
        if (resetn && o_wb_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("A writeback arrived with no accepted micro-op left to match it");
            end else begin
                wb_expected = exp_q.pop_front();
                check_wb(o_wb, wb_expected);
            end
        end
    end

    initial begin
        wait (table_loaded);
        repeat (RESET_CYCLES + 16 + n_entries * (`CPU_XLEN + 10)) @(posedge clk);
        report_failure("Timeout because writebacks stopped arriving before the table was done");
    end

    initial begin
        void'($urandom(SEED));
        resetn = 1'b0;
        i_uop_valid = 1'b0;
        i_uop = '0;
        table_loaded = 1'b0;
        load_table();
        table_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_ready(o_uop_ready, 1'b1, "ready after reset");
        end

        run_table();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // Idle tail catches stray writebacks
        repeat (8) @(negedge clk);

        $display("NO ERRORS");
        $finish;
    end

endmodule
